//--- hdl/chip_pkg.sv
// Bus and RAM definitions shared by every block of the core
// Addresses are word addresses; the RAM decodes only the low RAM_AW bits
`default_nettype none

package chip_pkg;

  // Bus widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;

  // Main RAM geometry
  localparam int RAM_WORDS = 1024;
  localparam int RAM_AW    = 10;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [RAM_AW-1:0] ram_idx_t;

  // One memory access, as issued by a port or by the arbiter
  typedef struct packed {
    logic  we;
    addr_t addr;
    data_t wdata;
  } mem_req_t;

endpackage

`default_nettype wire

//--- hdl/sw_status_pkg.sv
// Software test status conventions and the SPI loader frame format
// Status and log words sit at the top of the RAM and are matched on the full address
`default_nettype none

package sw_status_pkg;
  import chip_pkg::*;

  // Magic word addresses written by the test software
  localparam addr_t STATUS_ADDR = 16'h03FE;
  localparam addr_t LOG_ADDR    = 16'h03FF;

  // Status codes
  localparam data_t STATUS_PASS = 32'h0000_900D;
  localparam data_t STATUS_FAIL = 32'h0000_BAAD;

  // Loader frame is address followed by data, MSB first
  localparam int SPI_FRAME_BITS = 48;
  localparam int SPI_CNT_W      = $clog2(SPI_FRAME_BITS + 1);

  typedef logic [SPI_FRAME_BITS-1:0] spi_frame_t;
  typedef logic [SPI_CNT_W-1:0]      spi_cnt_t;

  typedef enum logic [1:0] {
    ST_RUNNING = 2'd0,
    ST_PASSED  = 2'd1,
    ST_FAILED  = 2'd2
  } test_status_e;

endpackage

`default_nettype wire

//--- hdl/main_ram.sv
// Single-port RAM, one access per enabled cycle
// Read data appears one cycle after the enabled edge and holds until the next read
// Upper address bits above RAM_AW alias onto the same words
`default_nettype none

module main_ram
  import chip_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     en_i,
  input  mem_req_t req_i,
  output data_t    rdata_o
);

  data_t    mem [RAM_WORDS];
  data_t    rdata_q;
  ram_idx_t idx;

  // Only the low index bits select a word
  assign idx = req_i.addr[RAM_AW-1:0];

  // Storage array
  always_ff @(posedge clk_i) begin
    if (en_i && req_i.we) begin
      mem[idx] <= req_i.wdata;
    end
  end

  // Read data register
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdata_q <= '0;
    end else if (en_i && !req_i.we) begin
      rdata_q <= mem[idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- hdl/ram_arbiter.sv
// Two-way round-robin arbiter in front of the main RAM
// Grants are combinational; a requester must hold valid and its request until granted
// After reset the host counts as last winner, so the loader wins the first tie
`default_nettype none

module ram_arbiter
  import chip_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  mem_req_t host_req_i,
  input  logic     host_valid_i,
  input  mem_req_t ldr_req_i,
  input  logic     ldr_valid_i,
  output logic     host_gnt_o,
  output logic     ldr_gnt_o,
  output mem_req_t ram_req_o,
  output logic     ram_en_o
);

  // High when the host took the most recent transfer
  logic host_last_q;

  // On a tie the requester that did not win last goes first
  always_comb begin
    host_gnt_o = 1'b0;
    ldr_gnt_o  = 1'b0;
    if (host_valid_i && ldr_valid_i) begin
      host_gnt_o = !host_last_q;
      ldr_gnt_o  = host_last_q;
    end else begin
      host_gnt_o = host_valid_i;
      ldr_gnt_o  = ldr_valid_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      host_last_q <= 1'b1;
    end else if (host_gnt_o) begin
      host_last_q <= 1'b1;
    end else if (ldr_gnt_o) begin
      host_last_q <= 1'b0;
    end
  end

  // Winner onto the RAM port
  assign ram_req_o = ldr_gnt_o ? ldr_req_i : host_req_i;
  assign ram_en_o  = host_gnt_o | ldr_gnt_o;

endmodule

`default_nettype wire

//--- hdl/spi_loader.sv
// Write-only SPI device, mode 0, MSB first, no MISO
// Pins are oversampled by clk_i, so SCK must stay below clk_i / 8
// A 48-bit frame is {addr[15:0], data[31:0]}; any other length is dropped
// A frame that completes while a write is still pending is dropped
`default_nettype none

module spi_loader
  import chip_pkg::*;
  import sw_status_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     spi_sck_i,
  input  logic     spi_csb_i,
  input  logic     spi_mosi_i,
  input  logic     gnt_i,
  output mem_req_t req_o,
  output logic     valid_o
);

  // Two sync stages plus one history stage for edge detection
  logic [2:0] sck_q;
  logic [2:0] csb_q;
  logic [1:0] mosi_q;

  logic sck_rise;
  logic csb_rise;
  logic csb_low;
  logic mosi_s;

  spi_frame_t shift_q;
  spi_cnt_t   cnt_q;
  logic       frame_ok;

  mem_req_t req_q;
  logic     valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sck_q  <= '0;
      // CSB idles high, so no false rising edge out of reset
      csb_q  <= '1;
      mosi_q <= '0;
    end else begin
      sck_q  <= {sck_q[1:0], spi_sck_i};
      csb_q  <= {csb_q[1:0], spi_csb_i};
      mosi_q <= {mosi_q[0], spi_mosi_i};
    end
  end

  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign csb_rise = csb_q[1] & ~csb_q[2];
  assign csb_low  = ~csb_q[1];
  assign mosi_s   = mosi_q[1];

  // Shift register holds payload only
  always_ff @(posedge clk_i) begin
    if (csb_low && sck_rise) begin
      shift_q <= {shift_q[SPI_FRAME_BITS-2:0], mosi_s};
    end
  end

  // Bit counter saturates so long frames never wrap back to a valid length
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (!csb_low) begin
      cnt_q <= '0;
    end else if (sck_rise && (cnt_q != '1)) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Counter is still intact in the cycle of the CSB edge
  assign frame_ok = csb_rise && (cnt_q == spi_cnt_t'(SPI_FRAME_BITS));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (valid_q) begin
      if (gnt_i) begin
        valid_q <= 1'b0;
      end
    end else if (frame_ok) begin
      valid_q <= 1'b1;
    end
  end

  // Request captured only when no write is pending
  always_ff @(posedge clk_i) begin
    if (frame_ok && !valid_q) begin
      req_q.we    <= 1'b1;
      req_q.addr  <= shift_q[SPI_FRAME_BITS-1:DATA_W];
      req_q.wdata <= shift_q[DATA_W-1:0];
    end
  end

  assign req_o   = req_q;
  assign valid_o = valid_q;

endmodule

`default_nettype wire

//--- hdl/sw_status_monitor.sv
// Watches granted RAM writes for the software status and log words
// Addresses are compared in full, so aliases of the magic words are ignored
// Outputs follow the write by one cycle
`default_nettype none

module sw_status_monitor
  import chip_pkg::*;
  import sw_status_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         ram_en_i,
  input  mem_req_t     ram_req_i,
  output logic         log_valid_o,
  output data_t        log_data_o,
  output test_status_e test_status_o,
  output logic         test_done_o
);

  logic         wr_en;
  logic         log_hit;
  logic         status_hit;
  logic         log_valid_q;
  data_t        log_data_q;
  test_status_e status_q;
  test_status_e status_d;

  assign wr_en      = ram_en_i && ram_req_i.we;
  assign log_hit    = wr_en && (ram_req_i.addr == LOG_ADDR);
  assign status_hit = wr_en && (ram_req_i.addr == STATUS_ADDR);

  // Any unknown code puts the test back to running
  always_comb begin
    status_d = status_q;
    if (status_hit) begin
      case (ram_req_i.wdata)
        STATUS_PASS: status_d = ST_PASSED;
        STATUS_FAIL: status_d = ST_FAILED;
        default:     status_d = ST_RUNNING;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      log_valid_q <= 1'b0;
      status_q    <= ST_RUNNING;
    end else begin
      log_valid_q <= log_hit;
      status_q    <= status_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (log_hit) begin
      log_data_q <= ram_req_i.wdata;
    end
  end

  assign log_valid_o   = log_valid_q;
  assign log_data_o    = log_data_q;
  assign test_status_o = status_q;
  assign test_done_o   = (status_q != ST_RUNNING);

endmodule

`default_nettype wire

//--- hdl/chip_core.sv
// Core top: host port and SPI loader share the main RAM through the arbiter
// host_rdata_o is valid only in the cycle host_rvalid_o is high
// Single clock domain; SPI pins are treated as asynchronous inputs
`default_nettype none

module chip_core
  import chip_pkg::*;
  import sw_status_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,

  // Host data port
  input  mem_req_t     host_req_i,
  input  logic         host_valid_i,
  output logic         host_gnt_o,
  output data_t        host_rdata_o,
  output logic         host_rvalid_o,

  // Debug pins in SPI mode
  input  logic         spi_sck_i,
  input  logic         spi_csb_i,
  input  logic         spi_mosi_i,

  // Software status observation
  output logic         log_valid_o,
  output data_t        log_data_o,
  output test_status_e test_status_o,
  output logic         test_done_o
);

  mem_req_t ldr_req;
  logic     ldr_valid;
  logic     ldr_gnt;
  mem_req_t ram_req;
  logic     ram_en;
  logic     host_rvalid_q;

  spi_loader u_spi_loader (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .spi_sck_i  (spi_sck_i),
    .spi_csb_i  (spi_csb_i),
    .spi_mosi_i (spi_mosi_i),
    .gnt_i      (ldr_gnt),
    .req_o      (ldr_req),
    .valid_o    (ldr_valid)
  );

  ram_arbiter u_ram_arbiter (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .host_req_i   (host_req_i),
    .host_valid_i (host_valid_i),
    .ldr_req_i    (ldr_req),
    .ldr_valid_i  (ldr_valid),
    .host_gnt_o   (host_gnt_o),
    .ldr_gnt_o    (ldr_gnt),
    .ram_req_o    (ram_req),
    .ram_en_o     (ram_en)
  );

  main_ram u_main_ram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .en_i    (ram_en),
    .req_i   (ram_req),
    .rdata_o (host_rdata_o)
  );

  sw_status_monitor u_sw_status_monitor (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .ram_en_i      (ram_en),
    .ram_req_i     (ram_req),
    .log_valid_o   (log_valid_o),
    .log_data_o    (log_data_o),
    .test_status_o (test_status_o),
    .test_done_o   (test_done_o)
  );

  // Read data returns one cycle after a granted host read
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      host_rvalid_q <= 1'b0;
    end else begin
      host_rvalid_q <= host_gnt_o && !host_req_i.we;
    end
  end

  assign host_rvalid_o = host_rvalid_q;

endmodule

`default_nettype wire

//--- tests/tb_assertions.sv
// Arbiter protocol checks, bound into every ram_arbiter instance
// Liveness check assumes requesters hold valid until granted
`default_nettype none

module tb_assertions (
  input logic clk_i,
  input logic rst_n_i,
  input logic host_valid_i,
  input logic ldr_valid_i,
  input logic host_gnt_i,
  input logic ldr_gnt_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Number of failed assertions
  int unsigned fail_cnt = 0;

  a_one_grant : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(host_gnt_i && ldr_gnt_i))
    else begin
      $error("Host and loader granted in the same cycle");
      fail_cnt++;
    end

  a_host_gnt_valid : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_gnt_i |-> host_valid_i)
    else begin
      $error("Host grant without host valid");
      fail_cnt++;
    end

  a_ldr_gnt_valid : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ldr_gnt_i |-> ldr_valid_i)
    else begin
      $error("Loader grant without loader valid");
      fail_cnt++;
    end

  // A waiting requester is served in the next cycle
  a_host_served : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (host_valid_i && !host_gnt_i) |=> host_gnt_i)
    else begin
      $error("Host request waited more than two cycles");
      fail_cnt++;
    end

  a_ldr_served : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ldr_valid_i && !ldr_gnt_i) |=> ldr_gnt_i)
    else begin
      $error("Loader request waited more than two cycles");
      fail_cnt++;
    end

endmodule

bind ram_arbiter tb_assertions u_arb_checks (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .host_valid_i (host_valid_i),
  .ldr_valid_i  (ldr_valid_i),
  .host_gnt_i   (host_gnt_o),
  .ldr_gnt_i    (ldr_gnt_o)
);

`default_nettype wire

//--- tests/tb.sv
// Table-driven testbench for chip_core with a reference memory model
// SPI pins are bit-banged at clk/8; reads only target words written earlier
`default_nettype none

module tb
  import chip_pkg::*;
  import sw_status_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [2:0] {OP_HWR, OP_HRD, OP_SWR, OP_SHORT, OP_BOTH} op_e;

  typedef struct packed {
    op_e   op;
    addr_t addr;
    data_t data;
    data_t tag;
  } entry_t;

  localparam int SCK_HALF     = 4;
  localparam int SHORT_BITS   = 40;
  localparam int FRAME_CYCLES = SPI_FRAME_BITS * 2 * SCK_HALF;

  logic         clk_i;
  logic         rst_n_i;
  mem_req_t     host_req;
  logic         host_valid;
  logic         host_gnt;
  data_t        host_rdata;
  logic         host_rvalid;
  logic         spi_sck;
  logic         spi_csb;
  logic         spi_mosi;
  logic         log_valid;
  data_t        log_data;
  test_status_e test_status;
  logic         test_done;

  entry_t       table_q [$];
  data_t        ref_mem [RAM_WORDS];
  int           seed          = 971;
  int           err_count     = 0;
  int           cycles        = 0;
  int           cycle_limit   = 1000;
  int           log_count     = 0;
  int           exp_log_count = 0;
  data_t        log_last      = '0;
  data_t        exp_log_data  = '0;
  test_status_e exp_status    = ST_RUNNING;

  chip_core dut (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .host_req_i    (host_req),
    .host_valid_i  (host_valid),
    .host_gnt_o    (host_gnt),
    .host_rdata_o  (host_rdata),
    .host_rvalid_o (host_rvalid),
    .spi_sck_i     (spi_sck),
    .spi_csb_i     (spi_csb),
    .spi_mosi_i    (spi_mosi),
    .log_valid_o   (log_valid),
    .log_data_o    (log_data),
    .test_status_o (test_status),
    .test_done_o   (test_done)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Log strobes seen at each edge, plus the run limit
  always @(posedge clk_i) begin
    cycles++;
    if (log_valid) begin
      log_count++;
      log_last = log_data;
    end
    if (cycles > cycle_limit) begin
      $display("Timeout: the DUT gave no grant or response within %0d cycles", cycle_limit);
      $display("Finished with errors");
      $finish;
    end
  end

  function automatic data_t rand_word();
    return data_t'($random(seed));
  endfunction

  task automatic add_entry(input op_e op, input addr_t addr, input data_t data);
    table_q.push_back('{op: op, addr: addr, data: data, tag: rand_word()});
  endtask

  task automatic check(input string what, input data_t act, input data_t exp);
    if (act !== exp) begin
      err_count++;
      $display("ERR @ %0t ns: %s, got %h, expected %h", $time, what, act, exp);
    end
  endtask

  function automatic void model_write(input addr_t addr, input data_t data);
    ref_mem[addr[RAM_AW-1:0]] = data;
    if (addr == LOG_ADDR) begin
      exp_log_count++;
      exp_log_data = data;
    end
    if (addr == STATUS_ADDR) begin
      exp_status = (data == STATUS_PASS) ? ST_PASSED :
                   (data == STATUS_FAIL) ? ST_FAILED : ST_RUNNING;
    end
  endfunction

  // Holds the request until granted, returns at the grant edge
  task automatic host_access(input logic we, input addr_t addr, input data_t wdata);
    @(posedge clk_i);
    host_req   <= '{we: we, addr: addr, wdata: wdata};
    host_valid <= 1'b1;
    @(negedge clk_i);
    while (!host_gnt) @(negedge clk_i);
    @(posedge clk_i);
    host_valid <= 1'b0;
  endtask

  // Mode 0, MSB first, low nbits of the frame
  task automatic spi_send(input spi_frame_t frame, input int nbits);
    @(posedge clk_i);
    spi_csb <= 1'b0;
    repeat (SCK_HALF) @(posedge clk_i);
    for (int i = nbits - 1; i >= 0; i--) begin
      spi_mosi <= frame[i];
      repeat (SCK_HALF) @(posedge clk_i);
      spi_sck <= 1'b1;
      repeat (SCK_HALF) @(posedge clk_i);
      spi_sck <= 1'b0;
    end
    repeat (SCK_HALF) @(posedge clk_i);
    spi_csb <= 1'b1;
  endtask

  task automatic wait_ldr_grant();
    @(negedge clk_i);
    while (!dut.ldr_gnt) @(negedge clk_i);
    @(posedge clk_i);
  endtask

  task automatic write_done(input addr_t addr, input data_t data);
    model_write(addr, data);
    @(negedge clk_i);
    check("test_status_o after write", data_t'(test_status), data_t'(exp_status));
    if (addr == LOG_ADDR) begin
      check("log_valid_o after log write", data_t'(log_valid), 32'd1);
      check("log_data_o after log write", log_data, data);
    end
  endtask

  task automatic read_check(input addr_t addr);
    @(negedge clk_i);
    check("host_rvalid_o after read grant", data_t'(host_rvalid), 32'd1);
    check($sformatf("read data at %h", addr), host_rdata, ref_mem[addr[RAM_AW-1:0]]);
    @(negedge clk_i);
    check("host_rvalid_o is a single pulse", data_t'(host_rvalid), '0);
  endtask

  // Host request raised in the same cycle the loader request appears
  task automatic both_write(input entry_t e);
    logic h_now;
    logic l_now;
    logic h_done;
    logic l_done;
    h_done = 1'b0;
    l_done = 1'b0;
    spi_send({e.addr, e.data}, SPI_FRAME_BITS);
    @(negedge clk_i);
    while (!dut.u_spi_loader.frame_ok) @(negedge clk_i);
    @(posedge clk_i);
    host_req   <= '{we: 1'b1, addr: addr_t'(e.addr + 16'd1), wdata: e.tag};
    host_valid <= 1'b1;
    @(negedge clk_i);
    check("host and loader pending together", data_t'({host_valid, dut.ldr_valid}), 32'd3);
    while (!(h_done && l_done)) begin
      h_now = host_gnt;
      l_now = dut.ldr_gnt;
      @(posedge clk_i);
      if (h_now) begin
        host_valid <= 1'b0;
        h_done = 1'b1;
      end
      l_done = l_done | l_now;
      @(negedge clk_i);
    end
    model_write(e.addr, e.data);
    model_write(addr_t'(e.addr + 16'd1), e.tag);
  endtask

  task automatic run_entry(input entry_t e);
    case (e.op)
      OP_HWR: begin
        host_access(1'b1, e.addr, e.data);
        write_done(e.addr, e.data);
      end
      OP_HRD: begin
        host_access(1'b0, e.addr, '0);
        read_check(e.addr);
      end
      OP_SWR: begin
        spi_send({e.addr, e.data}, SPI_FRAME_BITS);
        wait_ldr_grant();
        write_done(e.addr, e.data);
      end
      OP_SHORT: begin
        spi_send({e.addr, e.data}, SHORT_BITS);
        repeat (2 * SCK_HALF) begin
          @(negedge clk_i);
          check("request from a short frame", data_t'(dut.ldr_valid), '0);
        end
      end
      default: both_write(e);
    endcase
  endtask

  task automatic build_table();
    add_entry(OP_HWR, 16'h0010, rand_word());
    add_entry(OP_HWR, 16'h0011, rand_word());
    add_entry(OP_HRD, 16'h0010, '0);
    add_entry(OP_HRD, 16'h0011, '0);
    add_entry(OP_SWR, 16'h0020, rand_word());
    add_entry(OP_HRD, 16'h0020, '0);
    add_entry(OP_SHORT, 16'h0011, rand_word());
    add_entry(OP_HRD, 16'h0011, '0);
    add_entry(OP_HWR, LOG_ADDR, rand_word());
    add_entry(OP_SWR, LOG_ADDR, rand_word());
    add_entry(OP_HWR, STATUS_ADDR, STATUS_FAIL);
    add_entry(OP_SWR, STATUS_ADDR, STATUS_PASS);
    add_entry(OP_HWR, STATUS_ADDR, 32'h0000_1234);
    // Host won last, so the loader takes this tie
    add_entry(OP_BOTH, 16'h0030, rand_word());
    add_entry(OP_HRD, 16'h0030, '0);
    add_entry(OP_HRD, 16'h0031, '0);
    add_entry(OP_HRD, LOG_ADDR, '0);
    // Loader wins last here, so the host takes the next tie
    add_entry(OP_SWR, 16'h0040, rand_word());
    add_entry(OP_BOTH, 16'h0050, rand_word());
    add_entry(OP_HRD, 16'h0050, '0);
    add_entry(OP_HRD, 16'h0051, '0);
  endtask

  initial begin
    rst_n_i    <= 1'b0;
    host_valid <= 1'b0;
    host_req   <= '0;
    spi_sck    <= 1'b0;
    spi_csb    <= 1'b1;
    spi_mosi   <= 1'b0;
    build_table();
    cycle_limit = 20 + table_q.size() * (FRAME_CYCLES + 40);
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check("host_gnt_o after reset", data_t'(host_gnt), '0);
    check("host_rvalid_o after reset", data_t'(host_rvalid), '0);
    check("log_valid_o after reset", data_t'(log_valid), '0);
    check("test_status_o after reset", data_t'(test_status), data_t'(ST_RUNNING));
    foreach (table_q[i]) begin
      run_entry(table_q[i]);
      repeat (2) @(negedge clk_i);
      check($sformatf("log strobes after entry %0d", i), data_t'(log_count),
            data_t'(exp_log_count));
      check("last log word", log_last, exp_log_data);
      check("test_status_o", data_t'(test_status), data_t'(exp_status));
      check("test_done_o", data_t'(test_done), data_t'(exp_status != ST_RUNNING));
      check("loader idle", data_t'(dut.ldr_valid), '0);
    end
    $display("Check errors: %0d, assertion failures: %0d", err_count,
             dut.u_ram_arbiter.u_arb_checks.fail_cnt);
    if (err_count == 0 && dut.u_ram_arbiter.u_arb_checks.fail_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
hdl/chip_pkg.sv
hdl/sw_status_pkg.sv
hdl/main_ram.sv
hdl/ram_arbiter.sv
hdl/spi_loader.sv
hdl/sw_status_monitor.sv
hdl/chip_core.sv
tests/tb_assertions.sv
tests/tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module tb -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+100 > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "^Finished with no errors$" "$LOG"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1
